//--- tb.f
+incdir+.
tv_pkg.sv
frame_tick.sv
xbus_tv.sv
vram_ctrl.sv
tv_top.sv
tb_tv.sv

//--- tb_tv_tasks.svh
// Bus master and reporting tasks

`ifndef TB_TV_TASKS_SVH
`define TB_TV_TASKS_SVH

//////////////////////////////
// Reporting
//////////////////////////////

// Wrong value from the DUT
task automatic report_mismatch(input string name, input bus_data_t exp, input bus_data_t act);
   $display("FAILED %s: expected %h, actual %h", name, exp, act);
   errors++;
endtask

task automatic report_problem(input string name, input string what);
   $display("ERROR %s: %s", name, what);
   errors++;
endtask

// One line per finished test
task automatic close_test(input string name);
   tests++;
   if (errors == test_errors) begin
      $display("test %s: ok", name);
   end else begin
      tests_failed++;
      $display("test %s: %0d error(s)", name, errors - test_errors);
   end
   test_errors = errors;
endtask

//////////////////////////////
// Bus master
//////////////////////////////

// Full req/ack handshake
// hold keeps req up that many cycles past ack
task automatic bus_cycle(input bus_addr_t a, input logic wr, input bus_data_t d,
                         input int hold, output logic got_ack, output logic dec,
                         output bus_data_t rdata);
   int n;
   got_ack = 1'b0;
   rdata   = '0;
   @(posedge clk);
   addr   <= a;
   write  <= wr;
   datain <= d;
   req    <= 1'b1;
   @(negedge clk);
   dec = decode;
   // Frame buffer latency depends on scan traffic
   n = 0;
   while (!ack && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n++;
   end
   got_ack = ack;
   if (got_ack) begin
      rdata = dataout;
      // Memory model follows a completed frame buffer write
      if (wr && a[21:15] == FB_BASE[21:15]) begin
         ref_mem[a[14:0]] = d;
      end
      repeat (hold) begin
         @(posedge clk);
         datain <= ~d;
         @(negedge clk);
         assert (ack) else report_problem("hold", "ack fell while req was held");
      end
   end
   @(posedge clk);
   req <= 1'b0;
   n = 0;
   do begin
      @(negedge clk);
      n++;
   end while (ack && n < ACK_TIMEOUT);
   assert (!ack) else report_problem("bus", "ack stayed high after req dropped");
endtask

// Register and frame buffer targets only, both decoded
task automatic write_word(input string name, input bus_addr_t a, input bus_data_t d,
                          input int hold);
   logic      got_ack;
   logic      dec;
   bus_data_t rdata;
   bus_cycle(a, 1'b1, d, hold, got_ack, dec, rdata);
   assert (dec) else report_problem(name, "address not decoded on a write");
   assert (got_ack) else report_problem(name, "no ack for a write");
endtask

task automatic check_read(input string name, input bus_addr_t a, input bus_data_t exp);
   logic      got_ack;
   logic      dec;
   bus_data_t rdata;
   bus_cycle(a, 1'b0, '0, 0, got_ack, dec, rdata);
   assert (dec) else report_problem(name, "address not decoded on a read");
   assert (got_ack) else report_problem(name, "no ack for a read");
   assert (rdata == exp) else report_mismatch(name, exp, rdata);
endtask

// Stops as soon as interrupt is seen high
task automatic watch_interrupt(input int cycles, output logic high);
   int n;
   high = 1'b0;
   n = 0;
   while (!high && n < cycles) begin
      @(negedge clk);
      high = interrupt;
      n++;
   end
endtask

`endif

//--- tb_tv.sv
// Television interface testbench

`default_nettype none

module tb_tv;

   timeunit 1ns;
   timeprecision 1ps;

   import tv_pkg::*;

   // Short frame for simulation
   localparam int TICK_CYCLES = 400;
   localparam int ACK_TIMEOUT = 50;
   localparam int SCAN_TIMEOUT = 2000;
   localparam int NUM_WORDS = 12;

   // Status bits as the bus sees them
   localparam bus_data_t EN_MASK   = 32'(1) << INT_EN_BIT;
   localparam bus_data_t FLAG_MASK = 32'(1) << INT_FLAG_BIT;

   logic      clk = 1'b0;
   logic      reset;
   bus_addr_t addr;
   bus_data_t datain;
   logic      req;
   logic      write;
   bus_data_t dataout;
   logic      ack;
   logic      decode;
   logic      interrupt;
   bus_data_t scan_data;
   logic      scan_valid;

   // Expected frame buffer contents
   bus_data_t   ref_mem [0:VRAM_WORDS-1];
   // Scan pulses seen since reset
   int unsigned scan_count = 0;

   int seed;
   int errors = 0;
   int test_errors = 0;
   int tests = 0;
   int tests_failed = 0;

   `include "tb_tv_tasks.svh"

   always #50 clk = ~clk;

   tv_top #(
      .tick_cycles (TICK_CYCLES)
   ) i_dut (
      .clk        (clk),
      .reset      (reset),
      .addr       (addr),
      .datain     (datain),
      .req        (req),
      .write      (write),
      .dataout    (dataout),
      .ack        (ack),
      .decode     (decode),
      .interrupt  (interrupt),
      .scan_data  (scan_data),
      .scan_valid (scan_valid)
   );

   //////////////////////////////
   // Scan port and bus checks
   //////////////////////////////

   // Sampled at the edge, so a word written in the previous cycle is already in the model
   always @(posedge clk) begin
      if (scan_valid === 1'b1) begin
         assert (scan_data == ref_mem[vram_addr_t'(scan_count)])
            else report_mismatch("scan", ref_mem[vram_addr_t'(scan_count)], scan_data);
         scan_count = scan_count + 1;
      end
   end

   // Frame buffer window always decoded
   a_fb_decode: assert property (@(posedge clk) disable iff (reset)
      req && addr[21:15] == FB_BASE[21:15] |-> decode)
      else report_problem("decode", "frame buffer address not decoded");

   // Slave waits in done for the master
   a_ack_held: assert property (@(posedge clk) disable iff (reset)
      ack && req |=> ack)
      else report_problem("bus", "ack fell while req was held");

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin
      vram_addr_t offs [NUM_WORDS];
      bus_data_t  words [NUM_WORDS];
      bus_addr_t  probe [4];
      logic       acked;
      logic       decoded;
      logic       seen;
      bus_data_t  q;
      int unsigned start;
      int         n;

      seed   = 32'hd513_2f3f;
      reset  = 1'b1;
      req    = 1'b0;
      write  = 1'b0;
      addr   = '0;
      datain = '0;
      for (int i = 0; i < VRAM_WORDS; i++) begin
         ref_mem[i] = '0;
      end
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      // Random writes, then read back
      for (int i = 0; i < NUM_WORDS; i++) begin
         offs[i]  = vram_addr_t'($random(seed));
         words[i] = $random(seed);
         write_word("fb_readback", FB_BASE | offs[i], words[i], 0);
      end
      for (int i = 0; i < NUM_WORDS; i++) begin
         check_read("fb_readback", FB_BASE | offs[i], ref_mem[offs[i]]);
      end
      close_test("fb_readback");

      // Three unmapped addresses, color probe last
      probe[0] = 22'o00001234;
      probe[1] = 22'o17100000;
      probe[2] = 22'o17377740;
      probe[3] = COLOR_BASE | 22'o1234;
      for (int i = 0; i < 4; i++) begin
         bus_cycle(probe[i], 1'b0, '0, 0, acked, decoded, q);
         assert (!decoded) else report_mismatch("decode", 32'h0, {31'h0, decoded});
         assert (!acked) else report_problem("decode", "ack for an undecoded address");
      end
      // Probe read leaves zero behind
      assert (dataout == '0) else report_mismatch("decode", 32'h0, dataout);
      close_test("decode");

      // Enable, drop any old flag, then sync to a fresh tick
      write_word("interrupt", REG_BASE, EN_MASK | FLAG_MASK, 0);
      watch_interrupt(2 * TICK_CYCLES, seen);
      assert (seen) else report_problem("interrupt", "interrupt did not rise within two frames");
      check_read("interrupt", REG_BASE, EN_MASK | FLAG_MASK);
      write_word("interrupt", REG_BASE, EN_MASK | FLAG_MASK, 0);
      assert (!interrupt) else report_problem("interrupt", "interrupt still high after clear");
      check_read("interrupt", REG_BASE, EN_MASK);
      close_test("interrupt");

      // Enable off, flag still set by the next tick
      write_word("int_disabled", REG_BASE, FLAG_MASK, 0);
      watch_interrupt(TICK_CYCLES + 50, seen);
      assert (!seen) else report_problem("int_disabled", "interrupt rose while disabled");
      check_read("int_disabled", REG_BASE, FLAG_MASK);
      close_test("int_disabled");

      // Words just ahead of the scan address
      start = scan_count;
      for (int i = 0; i < 4; i++) begin
         write_word("scan", FB_BASE | vram_addr_t'(start + 64 + i), $random(seed), 0);
      end
      n = 0;
      while (scan_count < start + 70 && n < SCAN_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      assert (scan_count >= start + 70) else report_problem("scan", "scan port stopped");
      close_test("scan");

      // Held req with changed data must not write twice
      offs[0]  = vram_addr_t'($random(seed));
      words[0] = $random(seed);
      write_word("hold", FB_BASE | offs[0], words[0], 5);
      check_read("hold", FB_BASE | offs[0], ref_mem[offs[0]]);
      close_test("hold");

      $display("tests run %0d, failed %0d, errors %0d", tests, tests_failed, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tv_top.sv
// Television interface top

`default_nettype none

module tv_top #(
   parameter int unsigned tick_cycles = tv_pkg::TICK_CYCLES_DEFAULT
) (
   input  wire                     clk,
   input  wire                     reset,
   // CPU bus
   input  wire tv_pkg::bus_addr_t  addr,
   input  wire tv_pkg::bus_data_t  datain,
   input  wire                     req,
   input  wire                     write,
   output wire tv_pkg::bus_data_t  dataout,
   output wire                     ack,
   output wire                     decode,
   output wire                     interrupt,
   // Display scan
   output wire tv_pkg::bus_data_t  scan_data,
   output wire                     scan_valid
);

   import tv_pkg::*;

   wire        tick;

   // Slave to memory controller
   vram_addr_t vram_addr;
   bus_data_t  vram_data_out;
   bus_data_t  vram_data_in;
   wire        vram_req;
   wire        vram_write;
   wire        vram_ready;
   wire        vram_done;

   //////////////////////////////
   // Frame tick
   //////////////////////////////

   frame_tick #(
      .tick_cycles (tick_cycles)
   ) i_frame_tick (
      .clk   (clk),
      .reset (reset),
      .tick  (tick)
   );

   //////////////////////////////
   // Bus slave
   //////////////////////////////

   xbus_tv i_xbus_tv (
      .clk           (clk),
      .reset         (reset),
      .addr          (addr),
      .datain        (datain),
      .req           (req),
      .write         (write),
      .dataout       (dataout),
      .ack           (ack),
      .decode        (decode),
      .interrupt     (interrupt),
      .tick          (tick),
      .vram_addr     (vram_addr),
      .vram_data_out (vram_data_out),
      .vram_req      (vram_req),
      .vram_write    (vram_write),
      .vram_data_in  (vram_data_in),
      .vram_ready    (vram_ready),
      .vram_done     (vram_done)
   );

   //////////////////////////////
   // Video memory
   //////////////////////////////

   vram_ctrl i_vram_ctrl (
      .clk           (clk),
      .reset         (reset),
      .vram_addr     (vram_addr),
      .vram_data_out (vram_data_out),
      .vram_req      (vram_req),
      .vram_write    (vram_write),
      .vram_data_in  (vram_data_in),
      .vram_ready    (vram_ready),
      .vram_done     (vram_done),
      .scan_data     (scan_data),
      .scan_valid    (scan_valid)
   );

endmodule

`default_nettype wire

//--- vram_ctrl.sv
// Video memory controller

`default_nettype none

module vram_ctrl (
   input  wire                     clk,
   input  wire                     reset,
   // CPU access from the bus slave
   input  wire tv_pkg::vram_addr_t vram_addr,
   input  wire tv_pkg::bus_data_t  vram_data_out,
   input  wire                     vram_req,
   input  wire                     vram_write,
   output tv_pkg::bus_data_t       vram_data_in,
   output logic                    vram_ready,
   output logic                    vram_done,
   // Display scan port
   output tv_pkg::bus_data_t       scan_data,
   output logic                    scan_valid
);

   import tv_pkg::*;

   // Frame buffer store
   bus_data_t mem [0:VRAM_WORDS-1];

   // Single read port output
   bus_data_t  rd_word;
   vram_addr_t rd_addr;

   // Scan side
   vram_addr_t scan_addr;
   scan_cnt_t  interval_cnt;
   logic       scan_due;

   // CPU side
   logic cpu_busy;
   logic cpu_accept;
   logic cpu_read;
   logic cpu_write;

   // Power-up contents are all zero
   initial begin
      for (int i = 0; i < VRAM_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   //////////////////////////////
   // Scan timing
   //////////////////////////////

   assign scan_due = interval_cnt == '0;

   always_ff @(posedge clk) begin
      if (reset) begin
         interval_cnt <= scan_cnt_t'(SCAN_INTERVAL - 1);
      end else if (scan_due) begin
         interval_cnt <= scan_cnt_t'(SCAN_INTERVAL - 1);
      end else begin
         interval_cnt <= interval_cnt - 1'b1;
      end
   end

   // Step after every fetch
   // Wraps at 32K on its own width
   always_ff @(posedge clk) begin
      if (reset) begin
         scan_addr <= '0;
      end else if (scan_due) begin
         scan_addr <= scan_addr + 1'b1;
      end
   end

   //////////////////////////////
   // Arbiter
   //////////////////////////////

   // Answer pulse still out means the level is not yet dropped
   assign cpu_busy = vram_ready || vram_done;

   // Scan fetch takes the cycle
   assign cpu_accept = !scan_due && !cpu_busy && (vram_req || vram_write);
   assign cpu_read   = cpu_accept && vram_req;
   assign cpu_write  = cpu_accept && vram_write;

   // Read port shared by scan and CPU
   assign rd_addr = scan_due ? scan_addr : vram_addr;

   //////////////////////////////
   // Memory array
   //////////////////////////////

   always @(posedge clk) begin
      if (cpu_write) begin
         mem[vram_addr] <= vram_data_out;
      end
      rd_word <= mem[rd_addr];
   end

   //////////////////////////////
   // Answer and scan pulses
   //////////////////////////////

   // One cycle after accept
   always_ff @(posedge clk) begin
      if (reset) begin
         vram_ready <= 1'b0;
         vram_done  <= 1'b0;
         scan_valid <= 1'b0;
      end else begin
         vram_ready <= cpu_read;
         vram_done  <= cpu_write;
         scan_valid <= scan_due;
      end
   end

   // Word is valid only alongside its own pulse
   assign vram_data_in = rd_word;
   assign scan_data    = rd_word;

   // Read and write answers never overlap
   a_answer_excl: assert property (
      @(posedge clk) disable iff (reset) !(vram_ready && vram_done));

endmodule

`default_nettype wire

//--- xbus_tv.sv
// TV bus slave

`default_nettype none

module xbus_tv (
   input  wire                 clk,
   input  wire                 reset,
   // CPU bus
   input  wire tv_pkg::bus_addr_t  addr,
   input  wire tv_pkg::bus_data_t  datain,
   input  wire                 req,
   input  wire                 write,
   output tv_pkg::bus_data_t   dataout,
   output logic                ack,
   output logic                decode,
   output logic                interrupt,
   // Frame tick
   input  wire                 tick,
   // Video memory controller
   output tv_pkg::vram_addr_t  vram_addr,
   output tv_pkg::bus_data_t   vram_data_out,
   output logic                vram_req,
   output logic                vram_write,
   input  wire tv_pkg::bus_data_t  vram_data_in,
   input  wire                 vram_ready,
   input  wire                 vram_done
);

   import tv_pkg::*;

   tv_state_t state;
   tv_state_t state_next;

   // Window hits
   logic in_fb;
   logic in_color;
   logic in_reg;

   // Qualified requests
   logic bus_read;
   logic bus_write;
   logic reg_write;
   logic reg_read;
   logic color_read;
   logic flag_clear;

   // Status register
   logic      int_en;
   logic      int_flag;
   bus_data_t status;

   //////////////////////////////
   // Address decode
   //////////////////////////////

   assign in_fb    = addr[21:15] == FB_BASE[21:15];
   assign in_color = addr[21:15] == COLOR_BASE[21:15];
   // Any of the eight words hits status
   assign in_reg   = addr[21:3] == REG_BASE[21:3];

   // Color probe left out on a B&W board
   assign decode = in_reg || in_fb;

   assign bus_read  = req && !write;
   assign bus_write = req && write;

   // Register side effects only once per access
   assign reg_write  = bus_write && in_reg && state == tv_idle;
   assign reg_read   = bus_read && in_reg && state == tv_idle;
   assign color_read = bus_read && in_color;
   assign flag_clear = reg_write && datain[INT_FLAG_BIT];

   //////////////////////////////
   // Access FSM
   //////////////////////////////

   always_comb begin
      state_next = state;
      case (state)
         tv_idle: begin
            // Registers answer right away
            if (req && in_reg) begin
               state_next = tv_done;
            end else if (req && in_fb) begin
               state_next = write ? tv_write : tv_read;
            end
         end
         tv_write: begin
            if (vram_done) begin
               state_next = tv_done;
            end
         end
         tv_read: begin
            if (vram_ready) begin
               state_next = tv_done;
            end
         end
         tv_done: begin
            // Hold ack until master lets go
            if (!req) begin
               state_next = tv_idle;
            end
         end
         default: begin
            state_next = tv_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= tv_idle;
      end else begin
         state <= state_next;
      end
   end

   assign ack = state == tv_done;

   //////////////////////////////
   // Status and interrupt
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         int_en   <= 1'b0;
         int_flag <= 1'b0;
      end else begin
         if (reg_write) begin
            int_en <= datain[INT_EN_BIT];
         end
         // Tick beats a clear in the same cycle
         if (tick) begin
            int_flag <= 1'b1;
         end else if (flag_clear) begin
            int_flag <= 1'b0;
         end
      end
   end

   always_comb begin
      status = '0;
      status[INT_EN_BIT]   = int_en;
      status[INT_FLAG_BIT] = int_flag;
   end

   assign interrupt = int_en && int_flag;

   //////////////////////////////
   // Read data
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         dataout <= '0;
      end else if (reg_read) begin
         dataout <= status;
      end else if (color_read) begin
         // Probe reads as zero, no ack
         dataout <= '0;
      end else if (state == tv_read && vram_ready) begin
         dataout <= vram_data_in;
      end
   end

   //////////////////////////////
   // Memory controller side
   //////////////////////////////

   assign vram_addr     = addr[14:0];
   assign vram_data_out = datain;
   assign vram_req      = state == tv_read;
   assign vram_write    = state == tv_write;

   // Only one memory level at a time
   a_vram_levels_excl: assert property (
      @(posedge clk) disable iff (reset) !(vram_req && vram_write));

   // Ack only answers a live request
   a_ack_needs_req: assert property (
      @(posedge clk) disable iff (reset) $rose(ack) |-> req && $past(req));

endmodule

`default_nettype wire

//--- frame_tick.sv
// Frame interval tick

`default_nettype none

module frame_tick #(
   parameter int unsigned tick_cycles = tv_pkg::TICK_CYCLES_DEFAULT
) (
   input  wire  clk,
   input  wire  reset,
   output logic tick
);

   // Clocks left in the current frame
   logic [31:0] count;
   logic        count_zero;

   assign count_zero = count == '0;

   //////////////////////////////
   // Down counter
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= tick_cycles - 1;
      end else if (count_zero) begin
         // Reload for the next frame
         count <= tick_cycles - 1;
      end else begin
         count <= count - 1;
      end
   end

   // One-cycle pulse, registered
   // First one lands tick_cycles clocks out of reset
   always_ff @(posedge clk) begin
      if (reset) begin
         tick <= 1'b0;
      end else begin
         tick <= count_zero;
      end
   end

endmodule

`default_nettype wire

//--- tv_pkg.sv
// Television interface definitions

`default_nettype none

package tv_pkg;

   //////////////////////////////
   // Bus and memory widths
   //////////////////////////////

   // Word address on the CPU bus
   typedef logic [21:0] bus_addr_t;

   // One data word, bus side and memory side alike
   typedef logic [31:0] bus_data_t;

   // Word offset inside the frame buffer
   typedef logic [14:0] vram_addr_t;

   //////////////////////////////
   // Address windows
   //////////////////////////////

   // Frame buffer, matched on bits 21..15
   localparam bus_addr_t FB_BASE = 22'o17000000;

   // Color probe, matched on bits 21..15
   // Black-and-white board leaves it out of decode
   localparam bus_addr_t COLOR_BASE = 22'o17200000;

   // Eight-word register block, matched on bits 21..3
   localparam bus_addr_t REG_BASE = 22'o17377760;

   //////////////////////////////
   // Status register layout
   //////////////////////////////

   localparam int INT_EN_BIT = 3;
   // Write 1 here to clear the flag
   localparam int INT_FLAG_BIT = 4;

   //////////////////////////////
   // Timing
   //////////////////////////////

   // 50 MHz board clock over a 60 Hz frame
   localparam int unsigned TICK_CYCLES_DEFAULT = 833333;

   // Clocks between display scan fetches
   localparam int SCAN_INTERVAL = 8;
   localparam int SCAN_CNT_W = $clog2(SCAN_INTERVAL);
   typedef logic [SCAN_CNT_W-1:0] scan_cnt_t;

   // Frame buffer depth in words
   localparam int VRAM_WORDS = 32768;

   // Bus slave access FSM
   typedef enum logic [1:0] {
      tv_idle,
      tv_write,
      tv_read,
      tv_done
   } tv_state_t;

endpackage

`default_nettype wire
